// ==== files.f ====
+incdir+hw
hw/cache_pkg.sv
hw/l1_cache_control.sv
hw/l1_cache_datapath.sv
hw/mem_arbiter.sv
hw/main_memory.sv
hw/cache_system.sv
test/cache_system_tb.sv

// ==== test/cache_system_tb.sv ====
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_system_tb;

    import cache_pkg::*;

    localparam int RESP_TIMEOUT = 200;                  // Cycles a port may wait for mem_resp
    localparam int MEM_WORDS    = (1 << `ADDR_W) / (`WORD_W / 8);

    logic               clk;
    logic               rst_n;
    cpu_req_t           a_req;
    cpu_req_t           b_req;
    logic               a_resp;
    logic               b_resp;
    logic [`WORD_W-1:0] a_rdata;
    logic [`WORD_W-1:0] b_rdata;
    logic [`WORD_W-1:0] shadow [MEM_WORDS];             // Word-indexed copy of main memory
    logic               quiet;                          // No response allowed while set

    cache_system dut0 (
        .clk(clk), .rst_n(rst_n), .a_req(a_req), .b_req(b_req),
        .a_resp(a_resp), .b_resp(b_resp), .a_rdata(a_rdata), .b_rdata(b_rdata)
    );

    always #5 clk = ~clk;

    task automatic report_mismatch(input string port, input logic [`ADDR_W-1:0] addr,
                                   input logic [`WORD_W-1:0] exp,
                                   input logic [`WORD_W-1:0] got);
        $display("mismatch at %0t: port %s read of 0x%03h expected 0x%08h got 0x%08h",
                 $time, port, addr, exp, got);
        $display("TEST RESULT: FAIL");
        $fatal(1, "read data check failed");
    endtask

    task automatic report_failure(input string msg);
        $display("%0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "testbench check failed");
    endtask

    // Same fill rule as main memory, upper half C0DE and lower half the byte address
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = {16'hC0DE, 16'(i * (`WORD_W / 8))};
        end
    end

    always @(posedge clk) begin
        if (rst_n && a_resp && a_req.write && !a_req.read) shadow[a_req.addr >> 2] <= a_req.wdata;
        if (rst_n && b_resp && b_req.write && !b_req.read) shadow[b_req.addr >> 2] <= b_req.wdata;
    end

    a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
        (a_resp && a_req.read) |-> (a_rdata == shadow[a_req.addr >> 2]))
        else report_mismatch("A", $sampled(a_req.addr),
                             $sampled(shadow[a_req.addr >> 2]), $sampled(a_rdata));

    b_read_data: assert property (@(posedge clk) disable iff (!rst_n)
        (b_resp && b_req.read) |-> (b_rdata == shadow[b_req.addr >> 2]))
        else report_mismatch("B", $sampled(b_req.addr),
                             $sampled(shadow[b_req.addr >> 2]), $sampled(b_rdata));

    // Both bits set is a no-op and must never be answered
    a_resp_valid: assert property (@(posedge clk) disable iff (!rst_n)
        a_resp |-> (a_req.read != a_req.write))
        else report_failure("port A answered a request without exactly one of read or write");

    b_resp_valid: assert property (@(posedge clk) disable iff (!rst_n)
        b_resp |-> (b_req.read != b_req.write))
        else report_failure("port B answered a request without exactly one of read or write");

    no_resp_idle: assert property (@(posedge clk) disable iff (!rst_n)
        quiet |-> (!a_resp && !b_resp))
        else report_failure("a port responded while no request was presented");

    task automatic port_access(input bit port_b, input logic rd, input logic wr,
                               input logic [`ADDR_W-1:0] addr,
                               input logic [`WORD_W-1:0] wdata);
        cpu_req_t r;
        int       waited;
        r.read  = rd;
        r.write = wr;
        r.addr  = addr;
        r.wdata = wdata;
        waited  = 0;
        @(negedge clk);
        if (port_b) b_req = r;
        else a_req = r;
        #1;                                             // Let the combinational response settle
        while (!(port_b ? b_resp : a_resp)) begin
            if (waited >= RESP_TIMEOUT) begin
                report_failure(port_b ? "port B got no response" : "port A got no response");
            end
            waited++;
            @(negedge clk);
            #1;
        end
        @(posedge clk);                                 // Request completes at this edge
        @(negedge clk);
        if (port_b) b_req = '0;
        else a_req = '0;
    endtask

    task automatic random_traffic(input bit port_b, input int count);
        logic [`ADDR_W-1:0] addr;
        logic [`WORD_W-1:0] data;
        logic               rd;
        for (int i = 0; i < count; i++) begin
            addr = `ADDR_W'((port_b ? 512 : 0) + ($urandom % 128) * 4);
            data = $urandom;
            rd   = $urandom % 2;
            port_access(port_b, rd, !rd, addr, data);
        end
    endtask

    task automatic hold_both_set(input logic [`ADDR_W-1:0] addr,
                                 input logic [`WORD_W-1:0] wdata, input int cycles);
        @(negedge clk);
        a_req.read  = 1'b1;
        a_req.write = 1'b1;
        a_req.addr  = addr;
        a_req.wdata = wdata;
        repeat (cycles) @(negedge clk);
        a_req = '0;
    endtask

    initial begin
        void'($urandom(3));
        clk   = 1'b0;
        rst_n = 1'b0;
        a_req = '0;
        b_req = '0;
        quiet = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Idle window, then a cold read
        quiet = 1'b1;
        repeat (20) @(negedge clk);
        quiet = 1'b0;
        port_access(0, 1'b1, 1'b0, 10'h040, '0);

        // Write miss with fill, then hits
        port_access(0, 1'b0, 1'b1, 10'h084, 32'h1234_5678);
        port_access(0, 1'b1, 1'b0, 10'h084, '0);
        port_access(0, 1'b0, 1'b1, 10'h088, 32'hCAFE_0088);
        port_access(0, 1'b1, 1'b0, 10'h088, '0);
        port_access(0, 1'b1, 1'b0, 10'h084, '0);

        // Three tags in set 2 of cache B, the third write evicts a dirty line
        port_access(1, 1'b0, 1'b1, 10'h220, 32'hB000_0220);
        port_access(1, 1'b0, 1'b1, 10'h2A0, 32'hB000_02A0);
        port_access(1, 1'b0, 1'b1, 10'h320, 32'hB000_0320);
        port_access(1, 1'b1, 1'b0, 10'h220, '0);
        port_access(1, 1'b1, 1'b0, 10'h2A0, '0);
        port_access(1, 1'b1, 1'b0, 10'h320, '0);

        // Misses on both ports in the same cycle
        fork
            port_access(0, 1'b1, 1'b0, 10'h1C8, '0);
            port_access(1, 1'b1, 1'b0, 10'h3C8, '0);
        join

        fork
            random_traffic(0, 300);
            random_traffic(1, 300);
        join

        // Both bits set must not touch the word written earlier
        hold_both_set(10'h084, 32'hDEAD_BEEF, 10);
        port_access(0, 1'b1, 1'b0, 10'h084, '0);

        repeat (2) @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule : cache_system_tb

// ==== hw/cache_system.sv ====
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_system (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::cpu_req_t a_req,
    input  cache_pkg::cpu_req_t b_req,
    output logic                a_resp,
    output logic                b_resp,
    output logic [`WORD_W-1:0]  a_rdata,
    output logic [`WORD_W-1:0]  b_rdata
);

    import cache_pkg::*;

    cache_ctrl_t ctrl_a_s;
    cache_ctrl_t ctrl_b_s;
    cache_stat_t stat_a;
    cache_stat_t stat_b;
    wb_req_t     wb_a_req;
    wb_req_t     wb_b_req;
    wb_req_t     mem_req;
    wb_rsp_t     wb_a_rsp;
    wb_rsp_t     wb_b_rsp;
    wb_rsp_t     mem_rsp;

    // Port A cache
    l1_cache_control ctrl_a (
        .clk(clk), .rst_n(rst_n), .req(a_req), .stat(stat_a),
        .l2_resp(wb_a_rsp.ack), .ctrl(ctrl_a_s), .mem_resp(a_resp)
    );

    l1_cache_datapath dp_a (
        .clk(clk), .rst_n(rst_n), .req(a_req), .ctrl(ctrl_a_s),
        .wb_rsp(wb_a_rsp), .stat(stat_a), .rdata(a_rdata), .wb_req(wb_a_req)
    );

    // Port B cache
    l1_cache_control ctrl_b (
        .clk(clk), .rst_n(rst_n), .req(b_req), .stat(stat_b),
        .l2_resp(wb_b_rsp.ack), .ctrl(ctrl_b_s), .mem_resp(b_resp)
    );

    l1_cache_datapath dp_b (
        .clk(clk), .rst_n(rst_n), .req(b_req), .ctrl(ctrl_b_s),
        .wb_rsp(wb_b_rsp), .stat(stat_b), .rdata(b_rdata), .wb_req(wb_b_req)
    );

    mem_arbiter arb0 (
        .clk(clk), .rst_n(rst_n),
        .m0_req(wb_a_req), .m1_req(wb_b_req),
        .m0_rsp(wb_a_rsp), .m1_rsp(wb_b_rsp),
        .s_req(mem_req), .s_rsp(mem_rsp)
    );

    main_memory mem0 (
        .clk(clk), .rst_n(rst_n), .wb_req(mem_req), .wb_rsp(mem_rsp)
    );

endmodule : cache_system

// ==== hw/main_memory.sv ====
`timescale 1ns/100ps
`include "cache_cfg.svh"

module main_memory (
    input  logic               clk,
    input  logic               rst_n,
    input  cache_pkg::wb_req_t wb_req,
    output cache_pkg::wb_rsp_t wb_rsp
);

    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    logic [`LINE_W-1:0] mem [`MEM_LINES];
    logic [CNT_W-1:0]   cnt;
    logic               ack;

    initial begin
        for (int i = 0; i < `MEM_LINES; i++) begin
            for (int w = 0; w < `LINE_WORDS; w++) begin
                mem[i][w*`WORD_W +: `WORD_W] =
                    {16'hC0DE, 16'(i * (`LINE_W / 8) + w * (`WORD_W / 8))};
            end
        end
    end

    // Latency counter restarts after each ack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
            ack <= 1'b0;
        end else if (ack || !wb_req.stb) begin
            cnt <= '0;
            ack <= 1'b0;
        end else if (cnt == CNT_W'(`MEM_LATENCY - 1)) begin
            cnt <= '0;
            ack <= 1'b1;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ack && wb_req.we) mem[wb_req.adr] <= wb_req.dat;
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = mem[wb_req.adr];

    // The master has to keep its strobe up until the ack comes back
    a_ack_with_stb: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> wb_req.stb);

endmodule : main_memory

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    input  cache_pkg::wb_req_t m0_req,
    input  cache_pkg::wb_req_t m1_req,
    output cache_pkg::wb_rsp_t m0_rsp,
    output cache_pkg::wb_rsp_t m1_rsp,
    output cache_pkg::wb_req_t s_req,
    input  cache_pkg::wb_rsp_t s_rsp
);

    logic [1:0] gnt;        // One-hot owner, zero when the bus is free
    logic [1:0] gnt_next;
    logic [1:0] cyc;
    logic       last;       // Master served most recently

    assign cyc = {m1_req.cyc, m0_req.cyc};

    always_comb begin
        if (|(gnt & cyc)) begin
            gnt_next = gnt;                     // Owner keeps the bus
        end else if (&cyc) begin
            gnt_next = last ? 2'b01 : 2'b10;
        end else begin
            gnt_next = cyc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gnt  <= 2'b00;
            last <= 1'b1;
        end else begin
            gnt <= gnt_next;
            if (gnt_next[1]) begin
                last <= 1'b1;
            end else if (gnt_next[0]) begin
                last <= 1'b0;
            end
        end
    end

    always_comb begin
        if (gnt[1]) begin
            s_req = m1_req;
        end else if (gnt[0]) begin
            s_req = m0_req;
        end else begin
            s_req = '0;                         // Idle bus
        end
    end

    // Read data goes to both, ack only to the owner
    assign m0_rsp.ack = s_rsp.ack & gnt[0];
    assign m0_rsp.dat = s_rsp.dat;
    assign m1_rsp.ack = s_rsp.ack & gnt[1];
    assign m1_rsp.dat = s_rsp.dat;

    a_owner_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (|(gnt & cyc)) |=> (gnt == $past(gnt)));

endmodule : mem_arbiter

// ==== hw/l1_cache_datapath.sv ====
`timescale 1ns/100ps
`include "cache_cfg.svh"

module l1_cache_datapath (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cache_pkg::cpu_req_t    req,
    input  cache_pkg::cache_ctrl_t ctrl,
    input  cache_pkg::wb_rsp_t     wb_rsp,
    output cache_pkg::cache_stat_t stat,
    output logic [`WORD_W-1:0]     rdata,
    output cache_pkg::wb_req_t     wb_req
);

    localparam int BOFF_W = $clog2(`WORD_W / 8);
    localparam int WOFF_W = $clog2(`LINE_WORDS);

    logic [`TAG_W-1:0]      tag_q   [2][`CACHE_SETS];
    logic [`LINE_W-1:0]     line_q  [2][`CACHE_SETS];
    logic [`CACHE_SETS-1:0] valid_q [2];
    logic [`CACHE_SETS-1:0] dirty_q [2];
    logic [`CACHE_SETS-1:0] lru_q;

    logic [`TAG_W-1:0]  tag;
    logic [`IDX_W-1:0]  idx;
    logic [WOFF_W-1:0]  woff;
    logic [1:0]         hit;
    logic [`LINE_W-1:0] hit_line;
    logic [`LINE_W-1:0] new_line [2];
    logic [1:0]         load_td;
    logic [1:0]         load_d;
    logic [1:0]         load_v;
    logic [1:0]         d_set;
    logic [1:0]         v_set;

    assign tag  = req.addr[`ADDR_W-1 -: `TAG_W];
    assign idx  = req.addr[`OFF_W +: `IDX_W];
    assign woff = req.addr[BOFF_W +: WOFF_W];

    assign load_td = {ctrl.load_td1, ctrl.load_td0};
    assign load_d  = {ctrl.load_d1, ctrl.load_d0};
    assign load_v  = {ctrl.load_v1, ctrl.load_v0};
    assign d_set   = {ctrl.d_set1, ctrl.d_set0};
    assign v_set   = {ctrl.v_set1, ctrl.v_set0};

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit[w]      = valid_q[w][idx] && (tag_q[w][idx] == tag);
            new_line[w] = line_q[w][idx];
            new_line[w][woff*`WORD_W +: `WORD_W] = req.wdata;   // Write hit merge
            if (ctrl.l2_read) new_line[w] = wb_rsp.dat;
        end
    end

    assign stat.hit0   = hit[0];
    assign stat.hit1   = hit[1];
    assign stat.d_in0  = dirty_q[0][idx];
    assign stat.d_in1  = dirty_q[1][idx];
    assign stat.lru_in = lru_q[idx];

    assign hit_line = hit[1] ? line_q[1][idx] : line_q[0][idx];
    assign rdata    = hit_line[woff*`WORD_W +: `WORD_W];

    // Tag and line storage
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (load_td[w]) begin
                tag_q[w][idx]  <= tag;
                line_q[w][idx] <= new_line[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            dirty_q[0] <= '0;
            dirty_q[1] <= '0;
            lru_q      <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (load_v[w]) valid_q[w][idx] <= v_set[w];
                if (load_d[w]) dirty_q[w][idx] <= d_set[w];
            end
            if (ctrl.load_lru) lru_q[idx] <= ctrl.lru_set;
        end
    end

    always_comb begin
        wb_req.cyc = ctrl.l2_read | ctrl.l2_write;
        wb_req.stb = ctrl.l2_read | ctrl.l2_write;
        wb_req.we  = ctrl.l2_write;
        wb_req.dat = line_q[ctrl.l2wdata_sel][idx];
        case (ctrl.l2addr_sel)
            2'b01:   wb_req.adr = {tag_q[0][idx], idx};    // Victim in way 0
            2'b10:   wb_req.adr = {tag_q[1][idx], idx};
            default: wb_req.adr = req.addr[`ADDR_W-1:`OFF_W];
        endcase
    end

    // Fills only happen on a miss, so a tag is never present in both ways
    a_single_hit: assert property (@(posedge clk) disable iff (!rst_n)
        !(stat.hit0 && stat.hit1));

endmodule : l1_cache_datapath

// ==== hw/l1_cache_control.sv ====
`timescale 1ns/100ps

module l1_cache_control (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cache_pkg::cpu_req_t    req,
    input  cache_pkg::cache_stat_t stat,
    input  logic                   l2_resp,
    output cache_pkg::cache_ctrl_t ctrl,
    output logic                   mem_resp
);

    typedef enum logic [1:0] {
        process_request,
        fetch_cline,
        write_back
    } state_t;

    state_t state;
    state_t next_state;
    logic   req_valid;

    assign req_valid = req.read ^ req.write;   // Both set is a no-op

    always_comb begin
        ctrl     = '0;
        mem_resp = 1'b0;
        case (state)
            process_request: begin
                if (stat.hit0 && req_valid) begin
                    if (req.write) begin
                        ctrl.d_set0   = 1'b1;
                        ctrl.load_d0  = 1'b1;
                        ctrl.load_td0 = 1'b1;   // Merge the word into way 0
                    end
                    ctrl.lru_set  = 1'b1;       // Next victim is way 1
                    ctrl.load_lru = 1'b1;
                    mem_resp      = 1'b1;
                end
                if (stat.hit1 && req_valid) begin
                    if (req.write) begin
                        ctrl.d_set1   = 1'b1;
                        ctrl.load_d1  = 1'b1;
                        ctrl.load_td1 = 1'b1;
                    end
                    ctrl.lru_set     = 1'b0;
                    ctrl.load_lru    = 1'b1;
                    ctrl.l2wdata_sel = 1'b1;
                    mem_resp         = 1'b1;
                end
            end
            fetch_cline: begin
                ctrl.l2_read = 1'b1;
                if (l2_resp) begin          // Fill lands on the ack edge
                    if (!stat.lru_in) begin
                        ctrl.v_set0   = 1'b1;
                        ctrl.load_v0  = 1'b1;
                        ctrl.load_d0  = 1'b1;
                        ctrl.load_td0 = 1'b1;
                    end else begin
                        ctrl.v_set1   = 1'b1;
                        ctrl.load_v1  = 1'b1;
                        ctrl.load_d1  = 1'b1;
                        ctrl.load_td1 = 1'b1;
                    end
                end
            end
            write_back: begin
                ctrl.l2_write    = 1'b1;
                ctrl.l2wdata_sel = stat.lru_in;
                ctrl.l2addr_sel  = stat.lru_in ? 2'b10 : 2'b01;
            end
            default: ;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            process_request: begin
                if (!(stat.hit0 || stat.hit1) && req_valid) begin
                    if ((stat.d_in0 && !stat.lru_in) || (stat.d_in1 && stat.lru_in)) begin
                        next_state = write_back;
                    end else begin
                        next_state = fetch_cline;
                    end
                end
            end
            fetch_cline: begin
                if (l2_resp) next_state = process_request;
            end
            write_back: begin
                if (l2_resp) next_state = fetch_cline;
            end
            default: next_state = process_request;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= process_request;
        end else begin
            state <= next_state;
        end
    end

    a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.l2_read && ctrl.l2_write));

endmodule : l1_cache_control

// ==== hw/cache_pkg.sv ====
`include "cache_cfg.svh"

package cache_pkg;

    typedef struct packed {
        logic               read;
        logic               write;
        logic [`ADDR_W-1:0] addr;   // Byte address, word aligned
        logic [`WORD_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic       load_lru;
        logic       lru_set;
        logic       l2wdata_sel;    // Way that supplies write-back data
        logic       load_d0;
        logic       load_d1;
        logic       load_v0;
        logic       load_v1;
        logic       load_td0;       // Tag and line load, way 0
        logic       load_td1;
        logic       d_set0;
        logic       d_set1;
        logic       v_set0;
        logic       v_set1;
        logic [1:0] l2addr_sel;     // 0 CPU line, 1 way 0 tag, 2 way 1 tag
        logic       l2_read;
        logic       l2_write;
    } cache_ctrl_t;

    typedef struct packed {
        logic hit0;
        logic hit1;
        logic d_in0;
        logic d_in1;
        logic lru_in;   // Victim way of the addressed set
    } cache_stat_t;

    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        logic [`LADR_W-1:0] adr;    // Line address
        logic [`LINE_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic               ack;
        logic [`LINE_W-1:0] dat;
    } wb_rsp_t;

endpackage : cache_pkg

// ==== hw/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

`define CACHE_SETS  8
`define WORD_W      32
`define LINE_WORDS  4
`define ADDR_W      10
`define MEM_LINES   64
`define MEM_LATENCY 3

`define LINE_W  (`LINE_WORDS * `WORD_W)
`define OFF_W   ($clog2(`LINE_WORDS * `WORD_W / 8))
`define IDX_W   ($clog2(`CACHE_SETS))
`define TAG_W   (`ADDR_W - `IDX_W - `OFF_W)
`define LADR_W  (`ADDR_W - `OFF_W)

`endif
